/* cache_packet_generator.f */
+incdir+common
common/cache_packet_pkg.sv
common/way_status_if.sv
cache_packet_generator/write_way.sv
cache_packet_generator/read_way.sv
cache_packet_generator/selftest_status.sv
cache_packet_generator/cache_packet_generator.sv
test/cache_model.sv
test/tb_cache_packet_generator.sv

/* Makefile */
VERILATOR    = verilator
FLAGS        = --binary --timing --assert
TOP          = tb_cache_packet_generator
FILE_LIST    = cache_packet_generator.f
BUILD_DIR    = obj_dir
PASS_MESSAGE = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The status of the pipe is that of grep, so a run without the pass line fails.
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_cache_packet_generator.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_packet_settings.svh"

module tb_cache_packet_generator;

    import cache_packet_pkg::*;

    localparam logic [1:0] mode_normal   = 2'd0;
    localparam logic [1:0] mode_corrupt  = 2'd1;
    localparam logic [1:0] mode_withhold = 2'd2;
    localparam int finish_limit = 4000;
    localparam int reset_cycles = 10;
    localparam int num_request  = `CACHE_NUM_REQUEST;

    logic         clk_in;
    logic         reset_in;
    logic [1:0]   mode;
    packet_t      write_packet;
    logic         write_ack;
    packet_t      read_packet;
    logic         read_ack;
    packet_t      return_packet;
    logic         return_ack;
    logic         done;
    logic         error;
    error_cause_t error_cause;

    int   check_count;
    int   error_count;
    int   write_accepts;
    int   read_accepts;
    int   returns_seen;
    int   return_acks;
    int   halted_cycles;
    logic return_valid_q;
    logic return_ack_q;
    logic timed_out;

    cache_packet_generator uut
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .write_packet  (write_packet),
        .write_ack     (write_ack),
        .read_packet   (read_packet),
        .read_ack      (read_ack),
        .return_packet (return_packet),
        .return_ack    (return_ack),
        .done          (done),
        .error         (error),
        .error_cause   (error_cause)
    );

    cache_model cache
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .mode          (mode),
        .write_packet  (write_packet),
        .write_ack     (write_ack),
        .read_packet   (read_packet),
        .read_ack      (read_ack),
        .return_packet (return_packet),
        .return_ack    (return_ack)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // Each request owns one 16-byte block above the base address.
    function automatic addr_t expected_addr(int index);
        return addr_t'(`CACHE_BASE_ADDR + index * 16);
    endfunction

    function automatic block_t expected_block(int index);
        return {4{index}};
    endfunction

    task automatic check_that(input bit condition, input string message);
        check_count++;
        assert (condition)
        else
        begin
            error_count++;
            $display("** Error at %0t ns: %s", $time, message);
        end
    endtask

    task automatic apply_reset(input logic [1:0] scenario_mode);
        @(negedge clk_in);
        reset_in = 1'b1;
        mode     = scenario_mode;
        repeat (reset_cycles) @(negedge clk_in);
        reset_in = 1'b0;
    endtask

    task automatic wait_for_outcome(input string scenario);
        int cycles;
        cycles = 0;
        while (!done && !error && cycles < finish_limit)
        begin
            @(negedge clk_in);
            cycles++;
        end
        if (!done && !error)
        begin
            $display("Neither done nor error came within %0d cycles in the %s", cycles, scenario);
            timed_out = 1'b1;
        end
    endtask

    // Sampled on the rising edge before the DUT registers update.
    always @(posedge clk_in)
    begin
        if (reset_in)
        begin
            write_accepts  = 0;
            read_accepts   = 0;
            returns_seen   = 0;
            return_acks    = 0;
            halted_cycles  = 0;
            return_valid_q = 1'b0;
            return_ack_q   = 1'b0;
        end
        else
        begin
            if (write_packet[`CACHE_VALID_POS] && write_ack)
            begin
                check_that(write_accepts < num_request, "more than 16 writes accepted");
                check_that(write_packet[`CACHE_PORT_POS_HI:`CACHE_PORT_POS_LO] == 2'd0,
                    $sformatf("write %0d not on port 0", write_accepts));
                check_that(write_packet[`CACHE_IS_WRITE_POS] && write_packet[`CACHE_CACHEABLE_POS],
                    $sformatf("write %0d lacks the write or cacheable bit", write_accepts));
                check_that(write_packet[`CACHE_ADDR_POS_HI:`CACHE_ADDR_POS_LO]
                    == expected_addr(write_accepts),
                    $sformatf("write %0d has a wrong address", write_accepts));
                // Odd bytes only.
                check_that(write_packet[`CACHE_MASK_POS_HI:`CACHE_MASK_POS_LO] == 16'haaaa,
                    $sformatf("write %0d has a wrong mask", write_accepts));
                check_that(write_packet[`CACHE_DATA_POS_HI:`CACHE_DATA_POS_LO]
                    == expected_block(write_accepts),
                    $sformatf("write %0d has wrong data", write_accepts));
                write_accepts++;
            end
            if (read_packet[`CACHE_VALID_POS])
            begin
                check_that(write_accepts == num_request, "read issued before all write acks");
            end
            if (read_packet[`CACHE_VALID_POS] && read_ack)
            begin
                check_that(read_accepts < num_request, "more than 16 reads accepted");
                check_that(read_packet[`CACHE_PORT_POS_HI:`CACHE_PORT_POS_LO] == 2'd1,
                    $sformatf("read %0d not on port 1", read_accepts));
                check_that(!read_packet[`CACHE_IS_WRITE_POS] && read_packet[`CACHE_CACHEABLE_POS],
                    $sformatf("read %0d is not a cacheable read", read_accepts));
                check_that(read_packet[`CACHE_ADDR_POS_HI:`CACHE_ADDR_POS_LO]
                    == expected_addr(read_accepts),
                    $sformatf("read %0d has a wrong address", read_accepts));
                read_accepts++;
            end
            if (return_packet[`CACHE_VALID_POS] && !return_valid_q)
            begin
                returns_seen++;
            end
            if (return_ack)
            begin
                check_that(!return_ack_q, "return_ack high for two cycles");
                return_acks++;
            end
            if (mode == mode_normal)
            begin
                check_that(!error && error_cause == none, "error raised in a normal run");
            end
            check_that(!(done && error), "done and error both high");
            // One cycle after the error the engines must be frozen.
            if (halted_cycles >= 1)
            begin
                check_that(!write_packet[`CACHE_VALID_POS] && !read_packet[`CACHE_VALID_POS],
                    "request issued after halt");
            end
            halted_cycles  = error ? halted_cycles + 1 : 0;
            return_valid_q = return_packet[`CACHE_VALID_POS];
            return_ack_q   = return_ack;
        end
    end

    initial
    begin
        reset_in    = 1'b1;
        mode        = mode_normal;
        check_count = 0;
        error_count = 0;
        timed_out   = 1'b0;

        apply_reset(mode_normal);
        wait_for_outcome("normal run");
        if (!timed_out)
        begin
            repeat (20) @(negedge clk_in);
            check_that(done && !error && error_cause == none, "normal run did not finish clean");
            check_that(write_accepts == num_request && read_accepts == num_request,
                $sformatf("%0d writes and %0d reads accepted", write_accepts, read_accepts));
            check_that(returns_seen == num_request && return_acks == returns_seen,
                $sformatf("%0d returns got %0d acks", returns_seen, return_acks));
        end

        if (!timed_out)
        begin
            apply_reset(mode_corrupt);
            wait_for_outcome("corrupted return run");
        end
        if (!timed_out)
        begin
            repeat (20) @(negedge clk_in);
            check_that(error && error_cause == data_mismatch, "corrupt block not flagged");
            check_that(!done, "done rose despite a mismatch");
        end

        if (!timed_out)
        begin
            apply_reset(mode_withhold);
            wait_for_outcome("withheld ack run");
        end
        if (!timed_out)
        begin
            repeat (20) @(negedge clk_in);
            check_that(error && error_cause == write_timeout, "withheld acks not flagged");
            check_that(!done && read_accepts == 0,
                "done rose or reads were accepted while write acks were withheld");
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/cache_model.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_packet_settings.svh"

module cache_model
(
    input  wire                            clk_in,
    input  wire                            reset_in,
    input  wire [1:0]                      mode,
    input  wire cache_packet_pkg::packet_t write_packet,
    output logic                           write_ack,
    input  wire cache_packet_pkg::packet_t read_packet,
    output logic                           read_ack,
    output cache_packet_pkg::packet_t      return_packet,
    input  wire                            return_ack
);

    import cache_packet_pkg::*;

    localparam logic [1:0] mode_corrupt  = 2'd1;
    localparam logic [1:0] mode_withhold = 2'd2;
    // Returned block that gets one bit flipped.
    localparam int corrupt_index = 5;

    block_t mem [addr_t];
    addr_t  pending [$];
    int     seed;
    int     write_delay;
    int     read_delay;
    int     return_delay;
    int     return_index;

    function automatic int next_delay();
        return $unsigned($random(seed)) % 6;
    endfunction

    function automatic block_t merge_write(block_t old_data, block_t new_data, mask_t mask);
        block_t merged;
        merged = old_data;
        for (int i = 0; i < `CACHE_MASK_WIDTH; i++)
        begin
            if (mask[i])
            begin
                merged[i * 8 +: 8] = new_data[i * 8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic block_t lookup(addr_t addr);
        return mem.exists(addr) ? mem[addr] : '0;
    endfunction

    // One process drives every output, on the falling edge.
    initial
    begin
        addr_t  addr;
        block_t data;
        seed          = 32'hda7b;
        write_ack     = 1'b0;
        read_ack      = 1'b0;
        return_packet = '0;
        forever
        begin
            @(negedge clk_in);
            if (reset_in)
            begin
                write_ack     = 1'b0;
                read_ack      = 1'b0;
                return_packet = '0;
                write_delay   = 0;
                read_delay    = 0;
                return_delay  = 0;
                return_index  = 0;
                mem.delete();
                pending.delete();
            end
            else
            begin
                if (write_ack)
                begin
                    write_ack = 1'b0;
                end
                else if (write_packet[`CACHE_VALID_POS] && mode != mode_withhold)
                begin
                    if (write_delay == 0)
                    begin
                        addr = write_packet[`CACHE_ADDR_POS_HI:`CACHE_ADDR_POS_LO];
                        mem[addr] = merge_write(lookup(addr),
                            write_packet[`CACHE_DATA_POS_HI:`CACHE_DATA_POS_LO],
                            write_packet[`CACHE_MASK_POS_HI:`CACHE_MASK_POS_LO]);
                        write_ack   = 1'b1;
                        write_delay = next_delay();
                    end
                    else
                    begin
                        write_delay--;
                    end
                end

                if (read_ack)
                begin
                    read_ack = 1'b0;
                end
                else if (read_packet[`CACHE_VALID_POS])
                begin
                    if (read_delay == 0)
                    begin
                        pending.push_back(read_packet[`CACHE_ADDR_POS_HI:`CACHE_ADDR_POS_LO]);
                        read_ack   = 1'b1;
                        read_delay = next_delay();
                    end
                    else
                    begin
                        read_delay--;
                    end
                end

                // Returns go out in request order.
                if (return_packet[`CACHE_VALID_POS])
                begin
                    if (return_ack)
                    begin
                        return_packet = '0;
                        return_index++;
                    end
                end
                else if (pending.size() != 0)
                begin
                    if (return_delay == 0)
                    begin
                        addr = pending.pop_front();
                        data = lookup(addr);
                        if (mode == mode_corrupt && return_index == corrupt_index)
                        begin
                            data[0] = ~data[0];
                        end
                        return_packet = build_packet(addr, data, '0, port_t'(1), '0,
                            1'b1, 1'b0, 1'b1);
                        return_delay  = next_delay();
                    end
                    else
                    begin
                        return_delay--;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* cache_packet_generator/cache_packet_generator.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_packet_generator
(
    input  wire                                 clk_in,
    input  wire                                 reset_in,

    output wire cache_packet_pkg::packet_t      write_packet,
    input  wire                                 write_ack,

    output wire cache_packet_pkg::packet_t      read_packet,
    input  wire                                 read_ack,

    input  wire cache_packet_pkg::packet_t      return_packet,
    output wire                                 return_ack,

    output wire                                 done,
    output wire                                 error,
    output wire cache_packet_pkg::error_cause_t error_cause
);

    logic read_start;

    way_status_if write_status ();
    way_status_if read_status ();

    // Port 0.
    write_way write_engine
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .write_packet (write_packet),
        .write_ack    (write_ack),
        .status       (write_status)
    );

    // Port 1 starts after the writes.
    read_way read_engine
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .read_start    (read_start),
        .read_packet   (read_packet),
        .read_ack      (read_ack),
        .return_packet (return_packet),
        .return_ack    (return_ack),
        .status        (read_status)
    );

    selftest_status status_block
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .write_status (write_status),
        .read_status  (read_status),
        .read_start   (read_start),
        .done         (done),
        .error        (error),
        .error_cause  (error_cause)
    );

endmodule

`default_nettype wire

/* cache_packet_generator/selftest_status.sv */
`timescale 1ns/1ns
`default_nettype none

module selftest_status
(
    input  wire                             clk_in,
    input  wire                             reset_in,
    way_status_if.monitor                   write_status,
    way_status_if.monitor                   read_status,
    output logic                            read_start,
    output logic                            done,
    output logic                            error,
    output cache_packet_pkg::error_cause_t  error_cause
);

    import cache_packet_pkg::*;

    error_cause_t new_cause;
    logic         any_fault;

    // Mismatch wins over read timeout, read timeout over write timeout.
    always_comb
    begin
        if (read_status.mismatch)
        begin
            new_cause = data_mismatch;
        end
        else if (read_status.timeout)
        begin
            new_cause = read_timeout;
        end
        else if (write_status.timeout)
        begin
            new_cause = write_timeout;
        end
        else
        begin
            new_cause = none;
        end
    end

    assign any_fault = new_cause != none;

    // Both engines stop once an error is latched.
    assign write_status.halt = error;
    assign read_status.halt  = error;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            read_start  <= 1'b0;
            done        <= 1'b0;
            error       <= 1'b0;
            error_cause <= none;
        end
        else
        begin
            read_start <= write_status.done;
            if (!error && any_fault)
            begin
                error       <= 1'b1;
                error_cause <= new_cause;
            end
            if (write_status.done && read_status.done && !error && !any_fault)
            begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* cache_packet_generator/read_way.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_packet_settings.svh"

module read_way
(
    input  wire                       clk_in,
    input  wire                       reset_in,
    input  wire                       read_start,
    output cache_packet_pkg::packet_t read_packet,
    input  wire                       read_ack,
    input  wire cache_packet_pkg::packet_t return_packet,
    output logic                      return_ack,
    way_status_if.engine              status
);

    import cache_packet_pkg::*;

    localparam req_count_t last_request = req_count_t'(`CACHE_NUM_REQUEST - 1);
    localparam timeout_t   wait_limit   = timeout_t'(`CACHE_TIMEOUT_CYCLES);

    read_state_t state;
    req_count_t  issue_count;
    req_count_t  return_count;
    timeout_t    ack_wait;
    timeout_t    return_wait;
    logic        way_done;
    logic        way_mismatch;
    logic        return_seen;
    logic        outstanding;
    packet_t     next_packet;
    block_t      return_data;
    block_t      expected_data;

    assign next_packet = build_packet(request_addr(issue_count), '0, '0, port_t'(1), '0,
        1'b1, 1'b0, 1'b1);

    assign return_data   = return_packet[`CACHE_DATA_POS_HI:`CACHE_DATA_POS_LO];
    // Only the odd bytes were written.
    assign expected_data = fill_block(return_count) & expand_mask(`CACHE_WRITE_MASK);
    // A return still held after our ack is the same one.
    assign return_seen   = return_packet[`CACHE_VALID_POS] & ~return_ack;
    assign outstanding   = issue_count != return_count;

    assign status.done     = way_done;
    assign status.mismatch = way_mismatch;
    assign status.timeout  = (ack_wait == wait_limit) | (return_wait == wait_limit);

    // Request side.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state       <= read_idle;
            read_packet <= '0;
            issue_count <= '0;
            ack_wait    <= '0;
        end
        else if (status.halt)
        begin
            read_packet <= '0;
        end
        else
        begin
            case (state)
                read_idle:
                begin
                    if (read_start)
                    begin
                        state <= read_issue;
                    end
                end
                read_issue:
                begin
                    read_packet <= next_packet;
                    ack_wait    <= '0;
                    state       <= read_wait;
                end
                read_wait:
                begin
                    if (read_ack)
                    begin
                        read_packet <= '0;
                        ack_wait    <= '0;
                        issue_count <= issue_count + 1'b1;
                        state       <= (issue_count == last_request) ? read_drain : read_issue;
                    end
                    else if (ack_wait != wait_limit)
                    begin
                        ack_wait <= ack_wait + 1'b1;
                    end
                end
                default:
                begin
                    read_packet <= '0;
                end
            endcase
        end
    end

    // Returns are checked in issue order.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            return_ack   <= 1'b0;
            return_count <= '0;
            return_wait  <= '0;
            way_done     <= 1'b0;
            way_mismatch <= 1'b0;
        end
        else if (status.halt)
        begin
            return_ack <= 1'b0;
        end
        else
        begin
            return_ack <= return_seen;
            if (return_seen)
            begin
                return_count <= return_count + 1'b1;
                return_wait  <= '0;
                if (return_data != expected_data)
                begin
                    way_mismatch <= 1'b1;
                end
                else if (return_count == last_request)
                begin
                    way_done <= 1'b1;
                end
            end
            else if (!outstanding)
            begin
                return_wait <= '0;
            end
            else if (return_wait != wait_limit)
            begin
                return_wait <= return_wait + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* cache_packet_generator/write_way.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_packet_settings.svh"

module write_way
(
    input  wire                       clk_in,
    input  wire                       reset_in,
    output cache_packet_pkg::packet_t write_packet,
    input  wire                       write_ack,
    way_status_if.engine              status
);

    import cache_packet_pkg::*;

    localparam req_count_t last_request = req_count_t'(`CACHE_NUM_REQUEST - 1);
    localparam timeout_t   wait_limit   = timeout_t'(`CACHE_TIMEOUT_CYCLES);

    write_state_t state;
    req_count_t   request_count;
    timeout_t     wait_count;
    logic         way_done;
    packet_t      next_packet;

    assign next_packet = build_packet(request_addr(request_count), fill_block(request_count),
        `CACHE_WRITE_MASK, port_t'(0), '0, 1'b1, 1'b1, 1'b1);

    assign status.done     = way_done;
    assign status.timeout  = wait_count == wait_limit;
    // Writes are never checked here.
    assign status.mismatch = 1'b0;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state         <= write_issue;
            write_packet  <= '0;
            request_count <= '0;
            wait_count    <= '0;
            way_done      <= 1'b0;
        end
        else if (status.halt)
        begin
            // Frozen with no request visible.
            write_packet <= '0;
        end
        else
        begin
            case (state)
                write_issue:
                begin
                    write_packet <= next_packet;
                    wait_count   <= '0;
                    state        <= write_wait;
                end
                write_wait:
                begin
                    if (write_ack)
                    begin
                        write_packet  <= '0;
                        wait_count    <= '0;
                        request_count <= request_count + 1'b1;
                        if (request_count == last_request)
                        begin
                            way_done <= 1'b1;
                            state    <= write_finish;
                        end
                        else
                        begin
                            state <= write_issue;
                        end
                    end
                    else if (wait_count != wait_limit)
                    begin
                        wait_count <= wait_count + 1'b1;
                    end
                end
                default:
                begin
                    write_packet <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* common/way_status_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface way_status_if;

    logic done;
    logic timeout;
    logic mismatch;
    logic halt;

    modport engine
    (
        output done,
        output timeout,
        output mismatch,
        input  halt
    );

    modport monitor
    (
        input  done,
        input  timeout,
        input  mismatch,
        output halt
    );

endinterface

`default_nettype wire

/* common/cache_packet_pkg.sv */
`default_nettype none

`include "cache_packet_settings.svh"

package cache_packet_pkg;

    typedef logic [`CACHE_PACKET_WIDTH - 1:0] packet_t;
    typedef logic [`CACHE_ADDR_WIDTH - 1:0]   addr_t;
    typedef logic [`CACHE_BLOCK_WIDTH - 1:0]  block_t;
    typedef logic [`CACHE_MASK_WIDTH - 1:0]   mask_t;
    typedef logic [`CACHE_PORT_WIDTH - 1:0]   port_t;

    // Wide enough to hold the full request count.
    typedef logic [$clog2(`CACHE_NUM_REQUEST + 1) - 1:0]    req_count_t;
    typedef logic [$clog2(`CACHE_TIMEOUT_CYCLES + 1) - 1:0] timeout_t;

    typedef enum logic [1:0]
    {
        none,
        write_timeout,
        read_timeout,
        data_mismatch
    } error_cause_t;

    typedef enum logic [1:0]
    {
        write_issue,
        write_wait,
        write_finish
    } write_state_t;

    typedef enum logic [1:0]
    {
        read_idle,
        read_issue,
        read_wait,
        read_drain
    } read_state_t;

    function automatic packet_t build_packet(addr_t addr, block_t data, mask_t mask, port_t port,
        logic [`CACHE_TYPE_WIDTH - 1:0] kind, logic valid, logic is_write, logic cacheable);
        packet_t packet;
        packet = '0;
        packet[`CACHE_ADDR_POS_HI:`CACHE_ADDR_POS_LO] = addr;
        packet[`CACHE_DATA_POS_HI:`CACHE_DATA_POS_LO] = data;
        packet[`CACHE_MASK_POS_HI:`CACHE_MASK_POS_LO] = mask;
        packet[`CACHE_PORT_POS_HI:`CACHE_PORT_POS_LO] = port;
        packet[`CACHE_TYPE_POS_HI:`CACHE_TYPE_POS_LO] = kind;
        packet[`CACHE_VALID_POS] = valid;
        packet[`CACHE_IS_WRITE_POS] = is_write;
        packet[`CACHE_CACHEABLE_POS] = cacheable;
        return packet;
    endfunction

    // One 16-byte block per request.
    function automatic addr_t request_addr(req_count_t index);
        return addr_t'(`CACHE_BASE_ADDR) + (addr_t'(index) << $clog2(`CACHE_MASK_WIDTH));
    endfunction

    function automatic block_t fill_block(req_count_t index);
        return {(`CACHE_BLOCK_WIDTH / 32){32'(index)}};
    endfunction

    // Byte mask to bit mask.
    function automatic block_t expand_mask(mask_t mask);
        block_t bits;
        for (int i = 0; i < `CACHE_MASK_WIDTH; i++)
        begin
            bits[i * 8 +: 8] = {8{mask[i]}};
        end
        return bits;
    endfunction

endpackage

`default_nettype wire

/* common/cache_packet_settings.svh */
`ifndef CACHE_PACKET_SETTINGS_SVH
`define CACHE_PACKET_SETTINGS_SVH

// Field widths of one cache packet.
`define CACHE_ADDR_WIDTH        32
`define CACHE_BLOCK_WIDTH       128
`define CACHE_MASK_WIDTH        16
`define CACHE_PORT_WIDTH        2
`define CACHE_TYPE_WIDTH        2
`define CACHE_PACKET_WIDTH      183

// Packet layout from the lowest field up.
`define CACHE_ADDR_POS_LO       0
`define CACHE_ADDR_POS_HI       31
`define CACHE_DATA_POS_LO       32
`define CACHE_DATA_POS_HI       159
`define CACHE_MASK_POS_LO       160
`define CACHE_MASK_POS_HI       175
`define CACHE_PORT_POS_LO       176
`define CACHE_PORT_POS_HI       177
`define CACHE_TYPE_POS_LO       178
`define CACHE_TYPE_POS_HI       179
`define CACHE_VALID_POS         180
`define CACHE_IS_WRITE_POS      181
`define CACHE_CACHEABLE_POS     182

// Test sequence.
`define CACHE_NUM_REQUEST       16
`define CACHE_TIMEOUT_CYCLES    64
`define CACHE_BASE_ADDR         32'h0000_1000
// Every odd byte of a block.
`define CACHE_WRITE_MASK        16'haaaa

`endif
